// File: flist.f
+incdir+hw
hw/bomb_pkg.sv
hw/bomb_ifs.sv
hw/button_edge_detector.sv
hw/countdown_timer.sv
hw/game_control.sv
hw/wire_puzzle.sv
hw/code_puzzle.sv
hw/ssdec_spi_master.sv
hw/bomb_game.sv
tests/bomb_game_tb.sv

// File: hw/bomb_config.svh
`ifndef BOMB_CONFIG_SVH
`define BOMB_CONFIG_SVH

// Countdown start value, shown as M:ST
`define START_MIN      2
`define START_SEC_TEN  0
`define START_SEC_ONE  0

// Lives given at every start
`define START_LIVES    3

`define TICKS_PER_SEC  200   // Kept small so a game second is short in simulation
`define SCK_DIV        2     // Clock cycles per SPI clock half-period

`endif

// File: hw/bomb_game.sv
`timescale 1ns/1ps

module bomb_game (
    input  logic       clk,
    input  logic       reset,
    input  logic [5:0] button,
    input  logic [7:0] serial,
    output logic       ssdec_ss,
    output logic       ssdec_sck,
    output logic       ssdec_sdi,
    output logic [1:0] game_state
);

    logic [5:0] edges;
    logic       strobe;
    logic [1:0] lives;

    puzzle_if wire_bus (.edges(edges));
    puzzle_if code_bus (.edges(edges));
    timer_if  tmr_bus ();

    button_edge_detector u_buttons (
        .clk    (clk),
        .reset  (reset),
        .button (button),
        .edges  (edges),
        .strobe (strobe)
    );

    countdown_timer u_timer (
        .clk   (clk),
        .reset (reset),
        .tmr   (tmr_bus.timer)
    );

    game_control u_control (
        .clk        (clk),
        .reset      (reset),
        .strobe     (strobe),
        .edges      (edges),
        .serial     (serial),
        .wire_p     (wire_bus.control),
        .code_p     (code_bus.control),
        .tmr        (tmr_bus.control),
        .lives      (lives),
        .game_state (game_state)
    );

    wire_puzzle u_wire (.clk(clk), .reset(reset), .p(wire_bus.puzzle));
    code_puzzle u_code (.clk(clk), .reset(reset), .p(code_bus.puzzle));

    // Cleared bit 0 is the wire puzzle and bit 1 the code puzzle
    ssdec_spi_master u_ssdec (
        .clk     (clk),
        .reset   (reset),
        .lives   (lives),
        .cleared ({code_bus.cleared, wire_bus.cleared}),
        .tmr     (tmr_bus.control),
        .ss      (ssdec_ss),
        .sck     (ssdec_sck),
        .sdi     (ssdec_sdi)
    );

endmodule

// File: hw/bomb_ifs.sv
`timescale 1ns/1ps

// Link between the game FSM and one puzzle
interface puzzle_if (
    input logic [5:0] edges   // Button pulses, shared by every puzzle
);
    logic       active;
    logic       start;
    logic [7:0] serial;
    logic       error;
    logic       cleared;

    modport puzzle (
        input  active,
        input  start,
        input  serial,
        input  edges,
        output error,
        output cleared
    );

    modport control (
        output active,
        output start,
        output serial,
        input  error,
        input  cleared
    );
endinterface

interface timer_if;
    logic       load;
    logic       run;
    logic [3:0] min;
    logic [3:0] sec_ten;
    logic [3:0] sec_one;
    logic       expired;

    modport timer (input load, input run, output min, output sec_ten, output sec_one,
                   output expired);

    modport control (output load, output run, input min, input sec_ten, input sec_one,
                     input expired);
endinterface

// File: hw/bomb_pkg.sv
package bomb_pkg;

    ////////////////////
    // Game FSM
    ////////////////////

    typedef enum logic [1:0] {
        IDLE     = 2'd0,
        PLAYING  = 2'd1,
        DEFUSED  = 2'd2,
        EXPLODED = 2'd3
    } game_state_e;

    // Bit positions of the buttons in the button and edge vectors
    typedef enum logic [2:0] {
        SELECT = 3'd0,
        UP     = 3'd1,
        RIGHT  = 3'd2,
        DOWN   = 3'd3,
        LEFT   = 3'd4,
        BACK   = 3'd5
    } btn_e;

    ////////////////////
    // Display link
    ////////////////////

    // Frame is cleared, lives, min, sec_ten, sec_one
    localparam int FRAME_BITS = 16;

    typedef enum logic {
        IDLE_GAP = 1'b0,   // ss high between frames
        SHIFT    = 1'b1
    } spi_state_e;

endpackage

// File: hw/button_edge_detector.sv
`timescale 1ns/1ps

module button_edge_detector (
    input  logic       clk,
    input  logic       reset,
    input  logic [5:0] button,
    output logic [5:0] edges,
    output logic       strobe
);

    logic [5:0] sync_a;
    logic [5:0] sync_b;
    logic [5:0] prev;
    logic [5:0] rise;

    assign rise = sync_b & ~prev;   // High for one cycle per press

    always_ff @(posedge clk) begin
        if (reset) begin
            sync_a <= '0;
            sync_b <= '0;
            prev   <= '0;
            edges  <= '0;
            strobe <= 1'b0;
        end else begin
            sync_a <= button;
            sync_b <= sync_a;
            prev   <= sync_b;
            edges  <= rise;
            strobe <= |rise;
        end
    end

    // A pulse only ever follows a button that was high three cycles before
    a_edge_follows_button: assert property (
        @(posedge clk) disable iff (reset)
        (edges & ~$past(button, 3)) == '0
    );

endmodule

// File: hw/code_puzzle.sv
`timescale 1ns/1ps

module code_puzzle (
    input logic      clk,
    input logic      reset,
    puzzle_if.puzzle p
);

    logic [1:0] step;
    logic [1:0] dir_code;
    logic [3:0] want;       // Expected pulse on UP, RIGHT, DOWN, LEFT
    logic [3:0] dir_edges;

    // Direction codes 0 to 3 line up with button indices 1 to 4
    assign dir_code  = p.serial[{step, 1'b0} +: 2];
    assign want      = 4'b0001 << dir_code;
    assign dir_edges = p.edges[bomb_pkg::LEFT:bomb_pkg::UP];

    always_ff @(posedge clk) begin
        if (reset || p.start) begin
            step      <= 2'd0;
            p.error   <= 1'b0;
            p.cleared <= 1'b0;
        end else begin
            p.error <= 1'b0;
            if (p.active && !p.cleared && dir_edges != 4'd0) begin
                if (dir_edges == want) begin
                    step <= step + 2'd1;
                    if (step == 2'd3) p.cleared <= 1'b1;   // Fourth correct entry
                end else begin
                    step    <= 2'd0;   // Any wrong direction restarts the code
                    p.error <= 1'b1;
                end
            end
        end
    end

endmodule

// File: hw/countdown_timer.sv
`timescale 1ns/1ps
`include "bomb_config.svh"

module countdown_timer (
    input logic    clk,
    input logic    reset,
    timer_if.timer tmr
);

    localparam int TICK_W = $clog2(`TICKS_PER_SEC + 1);

    logic [TICK_W-1:0] tick_cnt;
    logic              sec_tick;
    logic              at_zero;

    assign sec_tick = (tick_cnt == TICK_W'(`TICKS_PER_SEC - 1));
    assign at_zero  = (tmr.min == 4'd0) && (tmr.sec_ten == 4'd0) && (tmr.sec_one == 4'd0);

    always_ff @(posedge clk) begin
        if (reset || tmr.load) begin
            tick_cnt    <= '0;
            tmr.min     <= 4'(`START_MIN);
            tmr.sec_ten <= 4'(`START_SEC_TEN);
            tmr.sec_one <= 4'(`START_SEC_ONE);
            tmr.expired <= 1'b0;
        end else if (tmr.run && !tmr.expired) begin
            if (sec_tick) begin
                tick_cnt <= '0;
                if (at_zero) begin
                    tmr.expired <= 1'b1;   // Digits stay at 0:00
                end else if (tmr.sec_one != 4'd0) begin
                    tmr.sec_one <= tmr.sec_one - 4'd1;
                end else begin
                    tmr.sec_one <= 4'd9;
                    if (tmr.sec_ten != 4'd0) begin
                        tmr.sec_ten <= tmr.sec_ten - 4'd1;
                    end else begin
                        tmr.sec_ten <= 4'd5;   // Borrow from the minutes
                        tmr.min     <= tmr.min - 4'd1;
                    end
                end
            end else begin
                tick_cnt <= tick_cnt + 1'b1;
            end
        end
    end

    a_sec_ten_range: assert property (
        @(posedge clk) disable iff (reset)
        tmr.sec_ten <= 4'd5
    );

endmodule

// File: hw/game_control.sv
`timescale 1ns/1ps
`include "bomb_config.svh"

module game_control (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  strobe,
    input  logic [5:0]            edges,
    input  logic [7:0]            serial,
    puzzle_if.control             wire_p,
    puzzle_if.control             code_p,
    timer_if.control              tmr,
    output logic [1:0]            lives,
    output bomb_pkg::game_state_e game_state
);

    bomb_pkg::game_state_e state;
    logic                  code_sel;   // Low selects the wire puzzle
    logic                  start_q;
    logic [7:0]            serial_q;
    logic                  err;
    logic                  press_select;
    logic                  press_back;

    assign err          = wire_p.error | code_p.error;
    assign press_select = strobe && edges[bomb_pkg::SELECT];
    assign press_back   = strobe && edges[bomb_pkg::BACK];

    ////////////////////
    // Game FSM
    ////////////////////

    always_ff @(posedge clk) begin
        if (reset) begin
            state    <= bomb_pkg::IDLE;
            lives    <= 2'(`START_LIVES);
            code_sel <= 1'b0;
            start_q  <= 1'b0;
        end else begin
            start_q <= 1'b0;
            case (state)
                bomb_pkg::IDLE: begin
                    if (press_select) begin
                        start_q  <= 1'b1;
                        code_sel <= 1'b0;
                        state    <= bomb_pkg::PLAYING;
                    end
                end
                bomb_pkg::PLAYING: begin
                    if (press_back) code_sel <= ~code_sel;
                    if (err) lives <= lives - 2'd1;
                    // Flags from the last game are still up while start is pulsing
                    if (!start_q) begin
                        if ((err && lives == 2'd1) || tmr.expired) begin
                            state <= bomb_pkg::EXPLODED;
                        end else if (wire_p.cleared && code_p.cleared) begin
                            state <= bomb_pkg::DEFUSED;
                        end
                    end
                end
                default: begin
                    if (press_select) begin
                        lives <= 2'(`START_LIVES);
                        state <= bomb_pkg::IDLE;
                    end
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (press_select && state == bomb_pkg::IDLE) serial_q <= serial;
    end

    assign game_state    = state;
    assign tmr.load      = start_q;
    assign tmr.run       = (state == bomb_pkg::PLAYING);
    assign wire_p.active = (state == bomb_pkg::PLAYING) && !code_sel;
    assign code_p.active = (state == bomb_pkg::PLAYING) && code_sel;
    assign wire_p.start  = start_q;
    assign code_p.start  = start_q;
    assign wire_p.serial = serial_q;
    assign code_p.serial = serial_q;

    // Lives run out only together with the explosion
    a_no_lives_exploded: assert property (
        @(posedge clk) disable iff (reset)
        (lives == 2'd0) |-> (state == bomb_pkg::EXPLODED)
    );

    // A puzzle reports an error only while it holds the buttons
    a_error_when_active: assert property (
        @(posedge clk) disable iff (reset)
        (!wire_p.error || $past(wire_p.active)) && (!code_p.error || $past(code_p.active))
    );

endmodule

// File: hw/ssdec_spi_master.sv
`timescale 1ns/1ps
`include "bomb_config.svh"

module ssdec_spi_master (
    input  logic       clk,
    input  logic       reset,
    input  logic [1:0] lives,
    input  logic [1:0] cleared,
    timer_if.control   tmr,
    output logic       ss,
    output logic       sck,
    output logic       sdi
);

    localparam int DIV_W = $clog2(`SCK_DIV + 1);

    bomb_pkg::spi_state_e              state;
    logic [DIV_W-1:0]                  div_cnt;
    logic [1:0]                        gap_cnt;
    logic [3:0]                        bit_cnt;
    logic [bomb_pkg::FRAME_BITS-1:0]   frame;
    logic [bomb_pkg::FRAME_BITS-1:0]   shreg;
    logic                              half_done;

    assign frame     = {cleared, lives, tmr.min, tmr.sec_ten, tmr.sec_one};
    assign half_done = (div_cnt == DIV_W'(`SCK_DIV - 1));
    assign sdi       = shreg[bomb_pkg::FRAME_BITS-1];   // MSB first

    always_ff @(posedge clk) begin
        if (reset) begin
            state   <= bomb_pkg::IDLE_GAP;
            ss      <= 1'b1;
            sck     <= 1'b0;
            div_cnt <= '0;
            gap_cnt <= 2'd0;
            bit_cnt <= 4'd0;
        end else begin
            case (state)
                bomb_pkg::IDLE_GAP: begin
                    gap_cnt <= gap_cnt + 2'd1;
                    if (gap_cnt == 2'd3) begin
                        state   <= bomb_pkg::SHIFT;
                        ss      <= 1'b0;
                        div_cnt <= '0;
                        bit_cnt <= 4'd0;
                    end
                end
                default: begin
                    div_cnt <= half_done ? '0 : div_cnt + 1'b1;
                    if (half_done) begin
                        sck <= ~sck;
                        if (sck) begin   // Falling edge
                            bit_cnt <= bit_cnt + 4'd1;
                            if (bit_cnt == 4'(bomb_pkg::FRAME_BITS - 1)) begin
                                state   <= bomb_pkg::IDLE_GAP;
                                ss      <= 1'b1;
                                gap_cnt <= 2'd0;
                            end
                        end
                    end
                end
            endcase
        end
    end

    // Frame is captured as ss falls and shifted on each falling sck
    always_ff @(posedge clk) begin
        if (state == bomb_pkg::IDLE_GAP && gap_cnt == 2'd3) begin
            shreg <= frame;
        end else if (state == bomb_pkg::SHIFT && half_done && sck) begin
            shreg <= {shreg[bomb_pkg::FRAME_BITS-2:0], 1'b0};
        end
    end

    a_sck_idle_low: assert property (
        @(posedge clk) disable iff (reset)
        ss |-> !sck
    );

endmodule

// File: hw/wire_puzzle.sv
`timescale 1ns/1ps

module wire_puzzle (
    input logic      clk,
    input logic      reset,
    puzzle_if.puzzle p
);

    logic [2:0] cursor;
    logic [5:0] cut;      // One bit per wire, set once cut
    logic [2:0] target;
    logic       live;

    // Six wires, so codes 6 and 7 fold back onto wires 4 and 5
    assign target = (p.serial[2:0] < 3'd6) ? p.serial[2:0] : p.serial[2:0] - 3'd2;
    assign live   = p.active && !p.cleared;

    always_ff @(posedge clk) begin
        if (reset || p.start) begin
            cursor    <= 3'd0;
            cut       <= '0;
            p.error   <= 1'b0;
            p.cleared <= 1'b0;
        end else begin
            p.error <= 1'b0;
            if (live) begin
                if (p.edges[bomb_pkg::LEFT] && cursor != 3'd0) begin
                    cursor <= cursor - 3'd1;
                end else if (p.edges[bomb_pkg::RIGHT] && cursor != 3'd5) begin
                    cursor <= cursor + 3'd1;
                end

                if (p.edges[bomb_pkg::SELECT]) begin
                    cut[cursor] <= 1'b1;
                    if (cut[cursor]) begin
                        p.error <= 1'b1;         // Wire was already cut
                    end else if (cursor == target) begin
                        p.cleared <= 1'b1;
                    end else begin
                        p.error <= 1'b1;
                    end
                end
            end
        end
    end

endmodule

// File: run_sim.sh
#!/bin/bash
# Builds and runs the testbench, failing unless the pass message is printed
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -Wno-fatal -f flist.f --top-module bomb_game_tb \
    -o sim_bomb &&
./obj_dir/sim_bomb | tee /dev/stderr | grep -q "Test passed" ||
exit 1

// File: tests/bomb_game_tb.sv
`timescale 1ns/1ps
`include "bomb_config.svh"

module bomb_game_tb;

    logic       clk;
    logic       reset;
    logic [5:0] button;
    logic [7:0] serial;
    logic       ssdec_ss;
    logic       ssdec_sck;
    logic       ssdec_sdi;
    logic [1:0] game_state;

    logic [15:0] shift_in;
    logic [15:0] last_frame;
    int          bit_count;
    int          frame_count;
    int          errors;
    int          checks;
    bit          timed_out;

    bomb_game dut (
        .clk        (clk),
        .reset      (reset),
        .button     (button),
        .serial     (serial),
        .ssdec_ss   (ssdec_ss),
        .ssdec_sck  (ssdec_sck),
        .ssdec_sdi  (ssdec_sdi),
        .game_state (game_state)
    );

    always #20 clk = ~clk;

    ////////////////////
    // SPI frame decoder
    ////////////////////

    always @(negedge ssdec_ss) bit_count = 0;

    always @(posedge ssdec_sck) begin
        if (!ssdec_ss) begin
            shift_in  = {shift_in[14:0], ssdec_sdi};   // MSB arrives first
            bit_count = bit_count + 1;
        end
    end

    always @(posedge ssdec_ss) begin
        if (bit_count == 16) begin
            last_frame  = shift_in;
            frame_count = frame_count + 1;
        end
    end

    task automatic press_and_release(input int idx);
        @(posedge clk);
        #5;
        if (idx < 6) button[idx] = 1'b1;
        repeat (5) @(posedge clk);
        #5;
        button = '0;
        repeat (5) @(posedge clk);
    endtask

    task automatic wait_two_frames(input string name);
        int start_count;
        int cycles;
        start_count = frame_count;
        cycles      = 0;
        while (frame_count < start_count + 2 && cycles < 1000) begin
            @(posedge clk);
            cycles++;
        end
        if (frame_count < start_count + 2) begin
            $display("Step %s timed out waiting for two display frames", name);
            errors++;
            timed_out = 1'b1;
        end
    endtask

    function automatic int to_seconds(input logic [11:0] t);
        return t[11:8] * 60 + t[7:4] * 10 + t[3:0];
    endfunction

    task automatic check_value(input string name, input string field, input int exp,
                               input int act);
        checks++;
        if (exp != act) begin
            $display("ERROR %s %s expected %0d actual %0d", name, field, exp, act);
            errors++;
        end
    endtask

    initial begin
        int          fd;
        int          n;
        string       line;
        string       name;
        string       tstr;
        int          ser;
        int          btn;
        int          secs;
        int          exp_state;
        int          exp_lives;
        int          exp_clr;
        logic [11:0] exp_time;
        logic [11:0] prev_time;
        clk         = 1'b0;
        reset       = 1'b1;
        button      = '0;
        serial      = '0;
        shift_in    = '0;
        last_frame  = '0;
        bit_count   = 0;
        frame_count = 0;
        errors      = 0;
        checks      = 0;
        timed_out   = 1'b0;
        prev_time   = '0;
        repeat (10) @(posedge clk);
        #5;
        reset = 1'b0;

        fd = $fopen("tests/bomb_vectors.txt", "r");
        if (fd == 0) begin
            $display("Could not open the vectors file");
            errors++;
        end else begin
            while (!$feof(fd) && !timed_out) begin
                line = "";
                n = $fgets(line, fd);
                if (n < 2 || line.substr(0, 0) == "#") continue;
                n = $sscanf(line, "%s %h %d %d %d %d %d %s", name, ser, btn, secs,
                            exp_state, exp_lives, exp_clr, tstr);
                if (n != 8) continue;
                serial = 8'(ser);
                press_and_release(btn);
                repeat (secs * `TICKS_PER_SEC) @(posedge clk);
                wait_two_frames(name);
                if (timed_out) break;

                check_value(name, "game_state", exp_state, game_state);
                check_value(name, "lives", exp_lives, last_frame[13:12]);
                check_value(name, "cleared", exp_clr, last_frame[15:14]);
                if (tstr == "===") begin
                    check_value(name, "time", prev_time, last_frame[11:0]);
                end else if (tstr != "---") begin
                    n = $sscanf(tstr, "%h", exp_time);
                    checks++;
                    // Frame latency may leave the shown time one second further on
                    if (to_seconds(last_frame[11:0]) != to_seconds(exp_time) &&
                        to_seconds(last_frame[11:0]) != to_seconds(exp_time) - 1) begin
                        $display("ERROR %s time expected %h actual %h", name, exp_time,
                                 last_frame[11:0]);
                        errors++;
                    end
                end
                prev_time = last_frame[11:0];
            end
            $fclose(fd);
        end

        $display("Checks run: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

// File: tests/bomb_vectors.txt
# name serial(hex) button(9=none) wait_sec state lives cleared time(hex M:ST, --- skip, === same)
# states 0 IDLE, 1 PLAYING, 2 DEFUSED, 3 EXPLODED; buttons 0 SEL 1 UP 2 RIGHT 3 DOWN 4 LEFT 5 BACK
after_reset    b2 9 0   0 3 0 200
idle_up        b2 1 0   0 3 0 200
idle_back      b2 5 0   0 3 0 200
start          b2 0 0   1 3 0 200
wait_five      b2 9 5   1 3 0 155
cursor_right   b2 2 0   1 3 0 ---
cut_wrong      b2 0 0   1 2 0 ---
cursor_right2  b2 2 0   1 2 0 ---
cut_right      b2 0 0   1 2 1 ---
swap_to_code   b2 5 0   1 2 1 ---
code_wrong     b2 1 0   1 1 1 ---
code_down      b2 3 0   1 1 1 ---
code_up        b2 1 0   1 1 1 ---
code_left      b2 4 0   1 1 1 ---
code_down2     b2 3 0   2 1 3 ---
frozen         b2 9 2   2 1 3 ===
back_to_idle   b2 0 0   0 3 3 ===
restart        b2 0 0   1 3 0 200
cut_zero       b2 0 0   1 2 0 ---
recut_zero     b2 0 0   1 1 0 ---
recut_again    b2 0 0   3 0 0 ---
idle_again     b2 0 0   0 3 0 ---
start_long     b2 0 0   1 3 0 200
run_out        b2 9 125 3 3 0 000
